// ==== all.f ====
+incdir+hw
hw/rename_pkg.sv
hw/tag_bus_if.sv
hw/rename_control.sv
hw/rob_tag_counter.sv
hw/map_table.sv
hw/rename_stage.sv
dv/rename_checker.sv
dv/rename_tb.sv

// ==== dv/rename_checker.sv ====
// rename stage checker
// reference model of the map table and ROB pointers, compared every cycle

`timescale 1ns/1ns

`include "rename_macros.svh"

module rename_checker (
   input logic                  clock,
   input logic                  reset,
   input logic                  inst1_valid,
   input rename_pkg::arch_reg_t inst1_rega,
   input rename_pkg::arch_reg_t inst1_regb,
   input rename_pkg::arch_reg_t inst1_dest,
   input logic                  inst2_valid,
   input rename_pkg::arch_reg_t inst2_rega,
   input rename_pkg::arch_reg_t inst2_regb,
   input rename_pkg::arch_reg_t inst2_dest,
   input rename_pkg::rob_tag_t  cdb1_tag,
   input rename_pkg::rob_tag_t  cdb2_tag,
   input logic [1:0]            retire_count,
   input logic                  flush,
   input rename_pkg::rob_tag_t  inst1_taga,
   input rename_pkg::rob_tag_t  inst1_tagb,
   input rename_pkg::rob_tag_t  inst2_taga,
   input rename_pkg::rob_tag_t  inst2_tagb,
   input rename_pkg::rob_tag_t  inst1_tag,
   input rename_pkg::rob_tag_t  inst2_tag,
   input logic                  stall
);

   // model state as it stands during the current cycle
   rename_pkg::rob_tag_t   model_table [`RENAME_NUM_REGS];
   rename_pkg::rob_index_t model_head;
   rename_pkg::rob_index_t model_tail;
   int                     in_flight;
   logic                   model_flush;

   // per test and whole run
   int test_checks  = 0;
   int test_errors  = 0;
   int total_checks = 0;
   int total_errors = 0;

   task automatic check_value(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
      test_checks++;
      total_checks++;
      if (actual !== expected)
      begin
         test_errors++;
         total_errors++;
         $display("Fail at %0t ns: %s expected %h actual %h", $time, name, expected, actual);
      end
   endtask

   // one summary line per test, then start counting afresh
   task automatic end_test(input string name);
      $display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
      test_checks = 0;
      test_errors = 0;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // reference functions
   ////////////////////////////////////////////////////////////////////////////

   // source lookup, inst1's new tag forwarded when it writes that register
   function automatic rename_pkg::rob_tag_t source_tag(input rename_pkg::arch_reg_t src,
      input logic fwd, input rename_pkg::rob_tag_t fwd_tag);
      if (fwd && (src == inst1_dest))
         return fwd_tag;
      return model_table[src];
   endfunction

   // entry after the edge: write, then retire, then CDB wakeup
   function automatic rename_pkg::rob_tag_t next_entry(input int r, input logic w1,
      input rename_pkg::rob_tag_t t1, input logic w2, input rename_pkg::rob_tag_t t2);
      rename_pkg::rob_tag_t entry;
      logic retired;
      logic ready;
      entry   = model_table[r];
      retired = ((retire_count >= 2'd1) && (entry[5:0] == model_head)) ||
                ((retire_count == 2'd2) && (entry[5:0] == model_head + 6'd1));
      ready   = ((cdb1_tag != `RENAME_TAG_NULL) && (cdb1_tag[5:0] == entry[5:0])) ||
                ((cdb2_tag != `RENAME_TAG_NULL) && (cdb2_tag[5:0] == entry[5:0]));
      if (r == `RENAME_ZERO_REG)
         return `RENAME_TAG_NULL;
      // younger slot wins
      if (w2 && (inst2_dest == r))
         return t2;
      if (w1 && (inst1_dest == r))
         return t1;
      if ((entry == `RENAME_TAG_NULL) || retired)
         return `RENAME_TAG_NULL;
      return ready ? (entry | 8'h40) : entry;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // per-cycle compare, outputs are settled by the falling edge
   ////////////////////////////////////////////////////////////////////////////

   always @(negedge clock)
   begin : compare_cycle
      logic                 stall_exp;
      logic                 a1;
      logic                 a2;
      logic                 w1;
      logic                 w2;
      rename_pkg::rob_tag_t t1;
      rename_pkg::rob_tag_t t2;
      if (reset)
      begin
         for (int i = 0; i < `RENAME_NUM_REGS; i++)
            model_table[i] = `RENAME_TAG_NULL;
         model_head  = '0;
         model_tail  = '0;
         in_flight   = 0;
         model_flush = 1'b0;
      end
      else
      begin
         // stalled in the flush cycle or with fewer than 2 free slots
         stall_exp = model_flush || ((`RENAME_ROB_DEPTH - in_flight) < 2);
         a1 = !stall_exp && inst1_valid;
         a2 = !stall_exp && inst2_valid;
         t1 = a1 ? {2'b00, model_tail} : `RENAME_TAG_NULL;
         t2 = a2 ? {2'b00, model_tail + {5'd0, a1}} : `RENAME_TAG_NULL;
         w1 = a1 && (inst1_dest != `RENAME_ZERO_REG);
         w2 = a2 && (inst2_dest != `RENAME_ZERO_REG);

         check_value("stall", {7'd0, stall_exp}, {7'd0, stall});
         check_value("inst1_tag", t1, inst1_tag);
         check_value("inst2_tag", t2, inst2_tag);
         check_value("inst1_taga", source_tag(inst1_rega, 1'b0, t1), inst1_taga);
         check_value("inst1_tagb", source_tag(inst1_regb, 1'b0, t1), inst1_tagb);
         check_value("inst2_taga", source_tag(inst2_rega, w1, t1), inst2_taga);
         check_value("inst2_tagb", source_tag(inst2_regb, w1, t1), inst2_tagb);

         if (retire_count > in_flight)
         begin
            test_errors++;
            total_errors++;
            $display("at %0t ns the stimulus retired %0d entries with only %0d in flight",
                     $time, retire_count, in_flight);
         end

         if (model_flush)
         begin
            // table and pool empty at the end of the flush cycle
            for (int i = 0; i < `RENAME_NUM_REGS; i++)
               model_table[i] = `RENAME_TAG_NULL;
            model_head = '0;
            model_tail = '0;
            in_flight  = 0;
         end
         else
         begin
            // each entry depends only on its own old value
            for (int i = 0; i < `RENAME_NUM_REGS; i++)
               model_table[i] = next_entry(i, w1, t1, w2, t2);
            model_head = model_head + {4'd0, retire_count};
            model_tail = model_tail + {5'd0, a1} + {5'd0, a2};
            in_flight  = in_flight + a1 + a2 - retire_count;
         end
         model_flush = flush;
      end
   end

endmodule

// ==== dv/rename_tb.sv ====
// rename stage testbench
// directed tests for lookup, forwarding, wakeup, retire and flush,
// then a random mix checked against the reference model

`timescale 1ns/1ns

`include "rename_macros.svh"

module rename_tb;

   localparam int random_cycles   = 400;
   // reset and two ROB fills of up to 40 cycles plus the short directed steps
   localparam int directed_cycles = 180;
   localparam int timeout_cycles  = directed_cycles + random_cycles + 40;

   logic                  clock;
   logic                  reset;
   logic                  inst1_valid;
   rename_pkg::arch_reg_t inst1_rega;
   rename_pkg::arch_reg_t inst1_regb;
   rename_pkg::arch_reg_t inst1_dest;
   logic                  inst2_valid;
   rename_pkg::arch_reg_t inst2_rega;
   rename_pkg::arch_reg_t inst2_regb;
   rename_pkg::arch_reg_t inst2_dest;
   rename_pkg::rob_tag_t  cdb1_tag;
   rename_pkg::rob_tag_t  cdb2_tag;
   logic [1:0]            retire_count;
   logic                  flush;
   rename_pkg::rob_tag_t  inst1_taga;
   rename_pkg::rob_tag_t  inst1_tagb;
   rename_pkg::rob_tag_t  inst2_taga;
   rename_pkg::rob_tag_t  inst2_tagb;
   rename_pkg::rob_tag_t  inst1_tag;
   rename_pkg::rob_tag_t  inst2_tag;
   logic                  stall;

   logic [31:0]           lfsr_state;
   rename_pkg::rob_tag_t  wake_tag;
   int                    allocated;
   logic [1:0]            retire_pick;

   rename_stage DUT (.*);

   rename_checker chk (.*);

   initial
   begin
      clock = 1'b0;
      forever #4 clock = ~clock;
   end

   ////////////////////////////////////////////////////////////////////////////
   // stimulus helpers
   ////////////////////////////////////////////////////////////////////////////

   // fibonacci LFSR with taps 32 22 2 1
   // one step per bit taken
   function automatic logic [31:0] lfsr_bits(input int count);
      logic [31:0] value;
      logic        feedback;
      value = '0;
      for (int i = 0; i < count; i++)
      begin
         feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], feedback};
         value      = {value[30:0], feedback};
      end
      return value;
   endfunction

   // half the time a real ROB index, otherwise no tag
   function automatic rename_pkg::rob_tag_t random_tag();
      logic [31:0] bits;
      bits = lfsr_bits(7);
      return bits[6] ? {2'b00, bits[5:0]} : `RENAME_TAG_NULL;
   endfunction

   task automatic clear_inputs();
      inst1_valid  <= 1'b0;
      inst1_rega   <= '0;
      inst1_regb   <= '0;
      inst1_dest   <= '0;
      inst2_valid  <= 1'b0;
      inst2_rega   <= '0;
      inst2_regb   <= '0;
      inst2_dest   <= '0;
      cdb1_tag     <= `RENAME_TAG_NULL;
      cdb2_tag     <= `RENAME_TAG_NULL;
      retire_count <= 2'd0;
      flush        <= 1'b0;
   endtask

   task automatic drive_pair(input logic v1, input rename_pkg::arch_reg_t a1, b1, d1,
                             input logic v2, input rename_pkg::arch_reg_t a2, b2, d2);
      inst1_valid <= v1;
      inst1_rega  <= a1;
      inst1_regb  <= b1;
      inst1_dest  <= d1;
      inst2_valid <= v2;
      inst2_rega  <= a2;
      inst2_regb  <= b2;
      inst2_dest  <= d2;
   endtask

   // start a new cycle with idle inputs
   // the caller then overrides what it needs
   task automatic next_cycle();
      @(posedge clock);
      clear_inputs();
   endtask

   // one idle cycle, then the checker closes the test
   task automatic finish_test(input string name);
      next_cycle();
      @(negedge clock);
      #1;
      chk.end_test(name);
   endtask

   // dispatch pairs until stall rises
   // first 8 pairs map regs 0..15 and the rest target reg 31
   task automatic fill_rob(output int count);
      count = 0;
      for (int i = 0; i < 40; i++)
      begin
         next_cycle();
         if (i < 8)
            drive_pair(1'b1, 5'(i), 5'(i + 8), 5'(i), 1'b1, 5'(i + 16), 5'(i), 5'(i + 8));
         else
            drive_pair(1'b1, 5'(i), 5'(i + 1), 5'd31, 1'b1, 5'(i + 2), 5'(i), 5'd31);
         @(negedge clock);
         if (stall)
            break;
         count += (inst1_tag != `RENAME_TAG_NULL) + (inst2_tag != `RENAME_TAG_NULL);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////////////////////////////////////////

   initial
   begin
      lfsr_state = 32'hc422;
      reset      = 1'b1;
      clear_inputs();
      repeat (3) @(posedge clock);
      reset <= 1'b0;

      // null table after reset and 64 tags before stall
      next_cycle();
      drive_pair(1'b0, 5'd0, 5'd5, 5'd0, 1'b0, 5'd17, 5'd31, 5'd0);
      fill_rob(allocated);
      chk.check_value("allocations", 8'd64, 8'(allocated));
      finish_test("reset");

      // oldest six retire so regs 0..2 and 8..10 go null
      next_cycle();
      retire_count <= 2'd2;
      drive_pair(1'b1, 5'd0, 5'd8, 5'd20, 1'b0, 5'd0, 5'd0, 5'd0);
      next_cycle();
      retire_count <= 2'd2;
      drive_pair(1'b1, 5'd1, 5'd9, 5'd20, 1'b0, 5'd0, 5'd0, 5'd0);
      next_cycle();
      retire_count <= 2'd2;
      next_cycle();
      drive_pair(1'b0, 5'd0, 5'd8, 5'd0, 1'b0, 5'd1, 5'd9, 5'd0);
      next_cycle();
      drive_pair(1'b0, 5'd2, 5'd10, 5'd0, 1'b0, 5'd3, 5'd20, 5'd0);
      finish_test("retire");

      // flush gives one stall cycle, then null reads and a full pool again
      next_cycle();
      flush <= 1'b1;
      drive_pair(1'b1, 5'd3, 5'd4, 5'd21, 1'b0, 5'd0, 5'd0, 5'd0);
      next_cycle();
      drive_pair(1'b1, 5'd21, 5'd3, 5'd22, 1'b1, 5'd4, 5'd5, 5'd23);
      for (int r = 0; r < 8; r++)
      begin
         next_cycle();
         drive_pair(1'b0, 5'(4 * r), 5'(4 * r + 1), 5'd0,
                    1'b0, 5'(4 * r + 2), 5'(4 * r + 3), 5'd0);
      end
      fill_rob(allocated);
      chk.check_value("allocations after flush", 8'd64, 8'(allocated));
      next_cycle();
      flush <= 1'b1;
      next_cycle();
      finish_test("flush");

      // renamed dest read back next cycle while reg 31 stays null
      next_cycle();
      drive_pair(1'b1, 5'd0, 5'd1, 5'd3, 1'b1, 5'd31, 5'd2, 5'd31);
      next_cycle();
      drive_pair(1'b0, 5'd3, 5'd31, 5'd0, 1'b1, 5'd31, 5'd3, 5'd31);
      finish_test("rename");

      // same-cycle dependence and write-write to one register
      next_cycle();
      drive_pair(1'b1, 5'd0, 5'd0, 5'd5, 1'b1, 5'd5, 5'd5, 5'd12);
      next_cycle();
      drive_pair(1'b1, 5'd1, 5'd2, 5'd6, 1'b1, 5'd6, 5'd3, 5'd6);
      next_cycle();
      drive_pair(1'b0, 5'd6, 5'd5, 5'd0, 1'b0, 5'd12, 5'd6, 5'd0);
      finish_test("forward");

      // wakeup of a mapped tag, a stray tag, and a write beating the CDB
      next_cycle();
      drive_pair(1'b1, 5'd0, 5'd0, 5'd7, 1'b0, 5'd0, 5'd0, 5'd0);
      @(negedge clock);
      wake_tag = inst1_tag;
      next_cycle();
      cdb1_tag <= wake_tag;
      cdb2_tag <= 8'h3f;
      next_cycle();
      drive_pair(1'b0, 5'd7, 5'd5, 5'd0, 1'b0, 5'd6, 5'd12, 5'd0);
      next_cycle();
      cdb2_tag <= wake_tag;
      drive_pair(1'b1, 5'd7, 5'd0, 5'd7, 1'b0, 5'd0, 5'd0, 5'd0);
      next_cycle();
      drive_pair(1'b0, 5'd7, 5'd7, 5'd0, 1'b0, 5'd0, 5'd0, 5'd0);
      finish_test("cdb");

      // random mix with retires limited to the model's in-flight count
      for (int i = 0; i < random_cycles; i++)
      begin
         next_cycle();
         drive_pair(1'(lfsr_bits(1)), 5'(lfsr_bits(5)), 5'(lfsr_bits(5)), 5'(lfsr_bits(5)),
                    1'(lfsr_bits(1)), 5'(lfsr_bits(5)), 5'(lfsr_bits(5)), 5'(lfsr_bits(5)));
         cdb1_tag <= random_tag();
         cdb2_tag <= random_tag();
         retire_pick = 2'(lfsr_bits(2));
         if (retire_pick == 2'd3)
            retire_pick = 2'd1;
         if (retire_pick > chk.in_flight)
            retire_pick = 2'(chk.in_flight);
         retire_count <= retire_pick;
         flush        <= (lfsr_bits(6) == 0);
      end
      finish_test("random");

      $display("total: %0d checks, %0d errors", chk.total_checks, chk.total_errors);
      if (chk.total_errors == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

   // cycle limit from the test lengths above
   initial
   begin : watchdog
      int cycles;
      cycles = 0;
      while (cycles < timeout_cycles)
      begin
         @(posedge clock);
         cycles++;
      end
      $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
      $display("Result: FAILED");
      $finish;
   end

endmodule

// ==== hw/map_table.sv ====
// rename map table
// maps each architectural register to the ROB tag of its newest writer,
// tracks the ready bit from the CDB and drops entries that retire or flush

`timescale 1ns/1ns

`include "rename_macros.svh"

module map_table (
   input  logic                  clock,
   input  logic                  reset,

   // source and destination registers of both slots
   input  rename_pkg::arch_reg_t inst1_rega,
   input  rename_pkg::arch_reg_t inst1_regb,
   input  rename_pkg::arch_reg_t inst1_dest,
   input  rename_pkg::arch_reg_t inst2_rega,
   input  rename_pkg::arch_reg_t inst2_regb,
   input  rename_pkg::arch_reg_t inst2_dest,

   // completing tags from the two CDBs
   input  rename_pkg::rob_tag_t  cdb1_tag,
   input  rename_pkg::rob_tag_t  cdb2_tag,

   // source tag lookups
   output rename_pkg::rob_tag_t  inst1_taga,
   output rename_pkg::rob_tag_t  inst1_tagb,
   output rename_pkg::rob_tag_t  inst2_taga,
   output rename_pkg::rob_tag_t  inst2_tagb,

   tag_bus_if.tbl                bus
);

   // one tag per architectural register
   rename_pkg::rob_tag_t tag_table  [`RENAME_NUM_REGS];
   rename_pkg::rob_tag_t next_table [`RENAME_NUM_REGS];

   // a slot writes only with a real tag (counter nulls reg 31 and idle slots)
   logic alloc1_write;
   logic alloc2_write;

   assign alloc1_write = (bus.alloc1_tag != `RENAME_TAG_NULL);
   assign alloc2_write = (bus.alloc2_tag != `RENAME_TAG_NULL);

   ////////////////////////////////////////////////////////////////////////////
   // source lookups
   ////////////////////////////////////////////////////////////////////////////

   // inst1 reads the table as it stands
   assign inst1_taga = reset ? `RENAME_TAG_NULL : tag_table[inst1_rega];
   assign inst1_tagb = reset ? `RENAME_TAG_NULL : tag_table[inst1_regb];

   // inst2 sees inst1's new tag when inst1 writes its source this cycle
   assign inst2_taga = reset ? `RENAME_TAG_NULL :
                       (alloc1_write && (inst2_rega == inst1_dest)) ? bus.alloc1_tag :
                       tag_table[inst2_rega];
   assign inst2_tagb = reset ? `RENAME_TAG_NULL :
                       (alloc1_write && (inst2_regb == inst1_dest)) ? bus.alloc1_tag :
                       tag_table[inst2_regb];

   ////////////////////////////////////////////////////////////////////////////
   // next table contents
   ////////////////////////////////////////////////////////////////////////////

   always_comb
   begin : next_entries
      rename_pkg::rob_tag_t entry;
      logic cdb_hit;
      logic retire_hit;

      for (int i = 0; i < `RENAME_NUM_REGS; i++)
      begin
         entry = tag_table[i];

         // exact tag match on either CDB
         cdb_hit = ((cdb1_tag != `RENAME_TAG_NULL) && (cdb1_tag == entry)) ||
                   ((cdb2_tag != `RENAME_TAG_NULL) && (cdb2_tag == entry));

         // retire compares the ROB index only, ready bit ignored
         retire_hit = ((bus.retire1_tag != `RENAME_TAG_NULL) &&
                       (bus.retire1_tag[5:0] == entry[5:0])) ||
                      ((bus.retire2_tag != `RENAME_TAG_NULL) &&
                       (bus.retire2_tag[5:0] == entry[5:0]));

         if ((i == `RENAME_ZERO_REG) || bus.clear_all)
         begin
            // zero reg pinned null, flush wipes everything
            next_table[i] = `RENAME_TAG_NULL;
         end
         else if (alloc2_write && (inst2_dest == 5'(i)))
         begin
            // inst2 is younger, so its write wins
            next_table[i] = bus.alloc2_tag;
         end
         else if (alloc1_write && (inst1_dest == 5'(i)))
         begin
            next_table[i] = bus.alloc1_tag;
         end
         else if ((entry == `RENAME_TAG_NULL) || retire_hit)
         begin
            // stays unmapped, or value now lives in the register file
            next_table[i] = `RENAME_TAG_NULL;
         end
         else
         begin
            // keep index, pick up ready bit from CDB
            next_table[i] = {1'b0, entry[6] | cdb_hit, entry[5:0]};
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // table registers
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         for (int i = 0; i < `RENAME_NUM_REGS; i++)
         begin
            tag_table[i] <= `RENAME_TAG_NULL;
         end
      end
      else
      begin
         tag_table <= next_table;
      end
   end

endmodule

// ==== hw/rename_control.sv ====
// rename control FSM
// run, full and flush states; gates dispatch and raises the table clear

`timescale 1ns/1ns

module rename_control (
   input  logic                    clock,
   input  logic                    reset,
   input  logic                    flush,
   input  rename_pkg::free_count_t free_count,
   output logic                    dispatch_enable,
   output logic                    clear_all,
   output logic                    stall
);

   rename_pkg::rename_state_t state;
   rename_pkg::rename_state_t next_state;

   // free_count already includes this cycle's allocs and retires,
   // so the next state matches the slots free in the next cycle
   always_comb
   begin
      case (state)
         rename_pkg::st_flush:
         begin
            // counter empties at this edge, back to run unless flushed again
            next_state = flush ? rename_pkg::st_flush : rename_pkg::st_run;
         end
         default:
         begin
            if (flush)
               next_state = rename_pkg::st_flush;
            else if (free_count < 7'd2)
               next_state = rename_pkg::st_full;
            else
               next_state = rename_pkg::st_run;
         end
      endcase
   end

   always_ff @(posedge clock)
   begin
      if (reset)
         state <= rename_pkg::st_run;
      else
         state <= next_state;
   end

   // dispatch only while running
   assign dispatch_enable = (state == rename_pkg::st_run);
   assign stall           = ~dispatch_enable;

   // table and counter clear for the one flush cycle
   assign clear_all = (state == rename_pkg::st_flush);

endmodule

// ==== hw/rename_macros.svh ====
// rename stage sizes and special values
// shared by the map table and the ROB tag counter

`ifndef RENAME_MACROS_SVH
`define RENAME_MACROS_SVH

// architectural register file size
`define RENAME_NUM_REGS 32

// ROB entries, one tag per entry
`define RENAME_ROB_DEPTH 64

// tag value meaning "not renamed"
`define RENAME_TAG_NULL 8'hff

// hardwired zero register, never mapped
`define RENAME_ZERO_REG 5'd31

`endif

// ==== hw/rename_pkg.sv ====
// rename stage types
// register numbers, ROB tags and the control state encoding

package rename_pkg;

   // architectural register number
   typedef logic [4:0] arch_reg_t;

   // ROB tag
   // bit 7 null flag (only 8'hff legal with it set)
   // bit 6 value ready in ROB
   // bits 5..0 ROB index
   typedef logic [7:0] rob_tag_t;

   // ROB slot index
   typedef logic [5:0] rob_index_t;

   // free ROB slots, 0..64
   typedef logic [6:0] free_count_t;

   // rename control FSM
   typedef enum logic [1:0] {st_run, st_full, st_flush} rename_state_t;

endpackage

// ==== hw/rename_stage.sv ====
// register rename stage, two instructions per cycle
// map table lookups, ROB tag allocation, CDB wakeup, retire and flush

`timescale 1ns/1ns

module rename_stage (
   input  logic                  clock,
   input  logic                  reset,

   // dispatch slot 1
   input  logic                  inst1_valid,
   input  rename_pkg::arch_reg_t inst1_rega,
   input  rename_pkg::arch_reg_t inst1_regb,
   input  rename_pkg::arch_reg_t inst1_dest,

   // dispatch slot 2, younger than slot 1
   input  logic                  inst2_valid,
   input  rename_pkg::arch_reg_t inst2_rega,
   input  rename_pkg::arch_reg_t inst2_regb,
   input  rename_pkg::arch_reg_t inst2_dest,

   // completion and retirement
   input  rename_pkg::rob_tag_t  cdb1_tag,
   input  rename_pkg::rob_tag_t  cdb2_tag,
   input  logic [1:0]            retire_count,
   input  logic                  flush,

   // source tags
   output rename_pkg::rob_tag_t  inst1_taga,
   output rename_pkg::rob_tag_t  inst1_tagb,
   output rename_pkg::rob_tag_t  inst2_taga,
   output rename_pkg::rob_tag_t  inst2_tagb,

   // newly allocated tags
   output rename_pkg::rob_tag_t  inst1_tag,
   output rename_pkg::rob_tag_t  inst2_tag,

   output logic                  stall
);

   logic                    dispatch_enable;
   logic                    clear_all;
   rename_pkg::free_count_t free_count;

   // alloc, retire and clear from counter to table
   tag_bus_if bus ();

   ////////////////////////////////////////////////////////////////////////////
   // control
   ////////////////////////////////////////////////////////////////////////////

   rename_control u_control (
      .clock           (clock),
      .reset           (reset),
      .flush           (flush),
      .free_count      (free_count),
      .dispatch_enable (dispatch_enable),
      .clear_all       (clear_all),
      .stall           (stall)
   );

   ////////////////////////////////////////////////////////////////////////////
   // tag pool and map table
   ////////////////////////////////////////////////////////////////////////////

   rob_tag_counter u_counter (
      .clock           (clock),
      .reset           (reset),
      .dispatch_enable (dispatch_enable),
      .inst1_valid     (inst1_valid),
      .inst2_valid     (inst2_valid),
      .inst1_dest      (inst1_dest),
      .inst2_dest      (inst2_dest),
      .retire_count    (retire_count),
      .clear_all       (clear_all),
      .free_count      (free_count),
      .inst1_tag       (inst1_tag),
      .inst2_tag       (inst2_tag),
      .bus             (bus.counter)
   );

   map_table u_map_table (
      .clock      (clock),
      .reset      (reset),
      .inst1_rega (inst1_rega),
      .inst1_regb (inst1_regb),
      .inst1_dest (inst1_dest),
      .inst2_rega (inst2_rega),
      .inst2_regb (inst2_regb),
      .inst2_dest (inst2_dest),
      .cdb1_tag   (cdb1_tag),
      .cdb2_tag   (cdb2_tag),
      .inst1_taga (inst1_taga),
      .inst1_tagb (inst1_tagb),
      .inst2_taga (inst2_taga),
      .inst2_tagb (inst2_tagb),
      .bus        (bus.tbl)
   );

endmodule

// ==== hw/rob_tag_counter.sv ====
// ROB tag counter
// circular head and tail over the ROB slots; hands out tags to new
// instructions in order and names the oldest ones when they retire

`timescale 1ns/1ns

`include "rename_macros.svh"

module rob_tag_counter (
   input  logic                    clock,
   input  logic                    reset,
   input  logic                    dispatch_enable,
   input  logic                    inst1_valid,
   input  logic                    inst2_valid,
   input  rename_pkg::arch_reg_t   inst1_dest,
   input  rename_pkg::arch_reg_t   inst2_dest,
   input  logic [1:0]              retire_count,
   input  logic                    clear_all,
   output rename_pkg::free_count_t free_count,
   output rename_pkg::rob_tag_t    inst1_tag,
   output rename_pkg::rob_tag_t    inst2_tag,
   tag_bus_if.counter              bus
);

   // oldest in-flight slot and next slot to hand out
   rename_pkg::rob_index_t head;
   rename_pkg::rob_index_t tail;

   // occupied slots now and after this cycle
   rename_pkg::free_count_t in_flight;
   rename_pkg::free_count_t next_in_flight;

   logic                   inst1_alloc;
   logic                   inst2_alloc;
   logic [1:0]             alloc_count;
   rename_pkg::rob_index_t inst2_index;
   rename_pkg::rob_index_t retire2_index;

   // allocation, inst1 takes the tail first
   assign inst1_alloc = dispatch_enable & inst1_valid;
   assign inst2_alloc = dispatch_enable & inst2_valid;
   assign alloc_count = {1'b0, inst1_alloc} + {1'b0, inst2_alloc};
   assign inst2_index = tail + rename_pkg::rob_index_t'(inst1_alloc);

   assign inst1_tag = inst1_alloc ? {2'b00, tail} : `RENAME_TAG_NULL;
   assign inst2_tag = inst2_alloc ? {2'b00, inst2_index} : `RENAME_TAG_NULL;

   // reg 31 still consumes a slot but never lands in the table
   assign bus.alloc1_tag = (inst1_dest == `RENAME_ZERO_REG) ? `RENAME_TAG_NULL : inst1_tag;
   assign bus.alloc2_tag = (inst2_dest == `RENAME_ZERO_REG) ? `RENAME_TAG_NULL : inst2_tag;

   // retire the one or two oldest
   assign retire2_index   = head + 6'd1;
   assign bus.retire1_tag = (retire_count != 2'd0) ? {2'b00, head} : `RENAME_TAG_NULL;
   assign bus.retire2_tag = (retire_count == 2'd2) ? {2'b00, retire2_index} : `RENAME_TAG_NULL;

   assign bus.clear_all = clear_all;

   // free slots as they will stand after this edge
   assign next_in_flight = in_flight + 7'(alloc_count) - 7'(retire_count);
   assign free_count     = clear_all ? 7'(`RENAME_ROB_DEPTH) :
                           7'(`RENAME_ROB_DEPTH) - next_in_flight;

   always_ff @(posedge clock)
   begin
      if (reset || clear_all)
      begin
         // empty ROB
         head      <= '0;
         tail      <= '0;
         in_flight <= '0;
      end
      else
      begin
         head      <= head + 6'(retire_count);
         tail      <= tail + 6'(alloc_count);
         in_flight <= next_in_flight;
      end
   end

endmodule

// ==== hw/tag_bus_if.sv ====
// tag bus between the ROB tag counter and the map table
// carries the allocated tags, the retiring tags and the flush clear

`timescale 1ns/1ns

interface tag_bus_if;

   // 8'hff means no write for this slot
   rename_pkg::rob_tag_t alloc1_tag;
   rename_pkg::rob_tag_t alloc2_tag;

   // 8'hff means nothing retires in this slot
   rename_pkg::rob_tag_t retire1_tag;
   rename_pkg::rob_tag_t retire2_tag;

   // level, high for the whole flush cycle
   logic clear_all;

   // tag producer side
   modport counter (output alloc1_tag, alloc2_tag, retire1_tag, retire2_tag, clear_all);

   // map table side
   modport tbl (input alloc1_tag, alloc2_tag, retire1_tag, retire2_tag, clear_all);

endinterface
